// File: rtl/npc_defines.svh
`ifndef NPC_DEFINES_SVH
`define NPC_DEFINES_SVH

// --------------------
// datapath sizes
// --------------------

// integer register width
`define NPC_XLEN 64

// architectural registers, x0 included
`define NPC_NREG 32

// instruction memory, in 32-bit words
`define NPC_IMEM_DEPTH 256

// --------------------
// fixed encodings
// --------------------

// ebreak stops the core once it retires
`define NPC_EBREAK 32'h0010_0073

`endif

// File: rtl/npc_isa_pkg.sv
package npc_isa_pkg;

    // --------------------
    // major opcodes
    // --------------------
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        SYSTEM = 7'b1110011,
        OTHER  = 7'b0000000
    } opcode_e;

    // funct3 values shared by the imm and reg forms
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    // funct7 of the reg-reg forms, alt selects sub
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // --------------------
    // alu operations
    // --------------------
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

endpackage

// File: rtl/npc_pipe_pkg.sv
`include "npc_defines.svh"

package npc_pipe_pkg;
    import npc_isa_pkg::*;

    typedef logic [`NPC_XLEN-1:0]         xlen_t;
    typedef logic [$clog2(`NPC_NREG)-1:0] reg_idx_t;

    // fetch to decode
    typedef struct packed {
        xlen_t       pc;
        logic [31:0] inst;
    } fs_to_ds_t;

    // decode to execute, operands as read from the register file
    typedef struct packed {
        xlen_t       pc;
        logic [31:0] inst;
        alu_op_e     alu_op;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        xlen_t       src_a;
        xlen_t       src_b;
        logic        use_imm;
        reg_idx_t    rd;
        logic        rf_we;
    } ds_to_es_t;

    // execute to writeback
    typedef struct packed {
        xlen_t       pc;
        logic [31:0] inst;
        reg_idx_t    rd;
        logic        rf_we;
        xlen_t       result;
    } es_to_ws_t;

    // register write, also the forwarding source
    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        xlen_t    data;
    } ws_to_rf_t;

    // one record per retired instruction
    typedef struct packed {
        xlen_t       pc;
        logic [31:0] inst;
        reg_idx_t    rd;
        logic        rf_we;
        xlen_t       data;
    } retire_t;

endpackage

// File: rtl/npc_fetch.sv
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_fetch import npc_pipe_pkg::*; (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               imem_we,
    input  logic [$clog2(`NPC_IMEM_DEPTH)-1:0] imem_addr,
    input  logic [31:0]                        imem_data,
    input  logic                               ds_allowin,
    output logic                               fs_to_ds_valid,
    output fs_to_ds_t                          fs_to_ds_bus
);

    localparam int IMEM_AW = $clog2(`NPC_IMEM_DEPTH);

    logic [31:0] imem [`NPC_IMEM_DEPTH];
    xlen_t       pc;
    logic        fs_allowin;

    // loaded by the testbench while reset is held
    always_ff @(posedge clk) begin
        if (reset && imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    assign fs_allowin = !fs_to_ds_valid || ds_allowin;

    // --------------------
    // pc and stage register
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pc             <= '0;
            fs_to_ds_valid <= 1'b0;
        end else if (fs_allowin) begin
            pc             <= pc + 4;
            fs_to_ds_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset && fs_allowin) begin
            fs_to_ds_bus.pc   <= pc;
            fs_to_ds_bus.inst <= imem[pc[IMEM_AW+1:2]];
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid |-> fs_to_ds_bus.pc[1:0] == 2'b00)
        else $error("fetch pc not word aligned");

endmodule

// File: rtl/npc_regfile.sv
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_regfile import npc_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_idx_t  rs1,
    input  reg_idx_t  rs2,
    output xlen_t     rdata1,
    output xlen_t     rdata2,
    input  ws_to_rf_t ws_to_rf_bus
);

    xlen_t regs [`NPC_NREG];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NPC_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (ws_to_rf_bus.we && ws_to_rf_bus.rd != '0) begin
            regs[ws_to_rf_bus.rd] <= ws_to_rf_bus.data;
        end
    end

    // write-through, decode sees the value written this cycle
    always_comb begin
        if (rs1 == '0) begin
            rdata1 = '0;
        end else if (ws_to_rf_bus.we && ws_to_rf_bus.rd == rs1) begin
            rdata1 = ws_to_rf_bus.data;
        end else begin
            rdata1 = regs[rs1];
        end

        if (rs2 == '0) begin
            rdata2 = '0;
        end else if (ws_to_rf_bus.we && ws_to_rf_bus.rd == rs2) begin
            rdata2 = ws_to_rf_bus.data;
        end else begin
            rdata2 = regs[rs2];
        end
    end

    // decode is expected to drop rf_we for rd == x0
    a_x0_clean: assert property (@(posedge clk) disable iff (reset)
        !(ws_to_rf_bus.we && ws_to_rf_bus.rd == '0 && ws_to_rf_bus.data != '0))
        else $error("nonzero write to x0");

endmodule

// File: rtl/npc_decode.sv
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_decode import npc_isa_pkg::*, npc_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds_bus,
    input  logic      es_allowin,
    output logic      ds_allowin,
    output reg_idx_t  rs1,
    output reg_idx_t  rs2,
    input  xlen_t     rdata1,
    input  xlen_t     rdata2,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es_bus
);

    logic [31:0] inst;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_idx_t    rd;
    xlen_t       imm_i;
    xlen_t       imm_u;
    xlen_t       src_b;
    opcode_e     opcode;
    alu_op_e     alu_op;
    logic        use_imm;
    logic        supported;
    logic        is_ebreak;
    logic        stop;
    logic        ds_accept;

    // --------------------
    // fields and immediates
    // --------------------
    assign inst   = fs_to_ds_bus.inst;
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign imm_i = {{(`NPC_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(`NPC_XLEN-32){inst[31]}}, inst[31:12], 12'b0};

    assign is_ebreak = (inst == `NPC_EBREAK);

    always_comb begin
        case (inst[6:0])
            OP_IMM:  opcode = OP_IMM;
            OP:      opcode = OP;
            LUI:     opcode = LUI;
            SYSTEM:  opcode = SYSTEM;
            default: opcode = OTHER;
        endcase
    end

    // operation select, unknown encodings fall through as no-ops
    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        supported = 1'b0;
        src_b     = rdata2;
        case (opcode)
            OP_IMM: begin
                use_imm   = 1'b1;
                supported = 1'b1;
                src_b     = imm_i;
                case (funct3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            OP: begin
                supported = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}: alu_op = ALU_ADD;
                    {F7_ALT, F3_ADD}:  alu_op = ALU_SUB;
                    {F7_BASE, F3_XOR}: alu_op = ALU_XOR;
                    {F7_BASE, F3_OR}:  alu_op = ALU_OR;
                    {F7_BASE, F3_AND}: alu_op = ALU_AND;
                    default:           supported = 1'b0;
                endcase
            end
            LUI: begin
                alu_op    = ALU_PASS_B;
                use_imm   = 1'b1;
                supported = 1'b1;
                src_b     = imm_u;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // --------------------
    // handshake and stop
    // --------------------
    assign ds_allowin = !stop && (!ds_to_es_valid || es_allowin);
    assign ds_accept  = fs_to_ds_valid && ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_to_es_valid <= 1'b0;
            stop           <= 1'b0;
        end else begin
            if (ds_allowin) begin
                ds_to_es_valid <= fs_to_ds_valid;
            end else if (es_allowin) begin
                // ebreak handed on, nothing follows it
                ds_to_es_valid <= 1'b0;
            end
            if (ds_accept && is_ebreak) begin
                stop <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ds_accept) begin
            ds_to_es_bus.pc      <= fs_to_ds_bus.pc;
            ds_to_es_bus.inst    <= inst;
            ds_to_es_bus.alu_op  <= alu_op;
            ds_to_es_bus.rs1     <= rs1;
            ds_to_es_bus.rs2     <= rs2;
            ds_to_es_bus.src_a   <= rdata1;
            ds_to_es_bus.src_b   <= src_b;
            ds_to_es_bus.use_imm <= use_imm;
            ds_to_es_bus.rd      <= rd;
            ds_to_es_bus.rf_we   <= supported && (rd != '0);
        end
    end

endmodule

// File: rtl/npc_execute.sv
`timescale 1ns/1ps

module npc_execute import npc_isa_pkg::*, npc_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ds_to_es_valid,
    input  ds_to_es_t ds_to_es_bus,
    input  logic      ws_allowin,
    output logic      es_allowin,
    input  ws_to_rf_t ws_to_rf_bus,
    output logic      es_to_ws_valid,
    output es_to_ws_t es_to_ws_bus
);

    logic  fwd_a;
    logic  fwd_b;
    xlen_t op_a;
    xlen_t op_b;
    xlen_t alu_result;
    logic  es_accept;

    // --------------------
    // forwarding from writeback
    // --------------------
    assign fwd_a = ws_to_rf_bus.we && ws_to_rf_bus.rd != '0
                   && ws_to_rf_bus.rd == ds_to_es_bus.rs1;
    assign fwd_b = ws_to_rf_bus.we && ws_to_rf_bus.rd != '0
                   && ws_to_rf_bus.rd == ds_to_es_bus.rs2;

    assign op_a = fwd_a ? ws_to_rf_bus.data : ds_to_es_bus.src_a;

    // immediate already sits in src_b
    always_comb begin
        if (ds_to_es_bus.use_imm) begin
            op_b = ds_to_es_bus.src_b;
        end else if (fwd_b) begin
            op_b = ws_to_rf_bus.data;
        end else begin
            op_b = ds_to_es_bus.src_b;
        end
    end

    always_comb begin
        case (ds_to_es_bus.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // --------------------
    // stage register
    // --------------------
    assign es_allowin = !es_to_ws_valid || ws_allowin;
    assign es_accept  = ds_to_es_valid && es_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_to_ws_valid <= 1'b0;
        end else if (es_allowin) begin
            es_to_ws_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_accept) begin
            es_to_ws_bus.pc     <= ds_to_es_bus.pc;
            es_to_ws_bus.inst   <= ds_to_es_bus.inst;
            es_to_ws_bus.rd     <= ds_to_es_bus.rd;
            es_to_ws_bus.rf_we  <= ds_to_es_bus.rf_we;
            es_to_ws_bus.result <= alu_result;
        end
    end

    a_alu_op_known: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> !$isunknown(ds_to_es_bus.alu_op))
        else $error("unknown alu_op from decode");

endmodule

// File: rtl/npc_writeback.sv
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_writeback import npc_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      es_to_ws_valid,
    input  es_to_ws_t es_to_ws_bus,
    output logic      ws_allowin,
    output ws_to_rf_t ws_to_rf_bus,
    output logic      retire_valid,
    output retire_t   retire,
    output logic      halted
);

    // last stage, never stalls
    assign ws_allowin = 1'b1;

    always_comb begin
        ws_to_rf_bus.we   = es_to_ws_valid && es_to_ws_bus.rf_we;
        ws_to_rf_bus.rd   = es_to_ws_bus.rd;
        ws_to_rf_bus.data = es_to_ws_bus.result;
    end

    // retire record
    assign retire_valid = es_to_ws_valid;

    always_comb begin
        retire.pc    = es_to_ws_bus.pc;
        retire.inst  = es_to_ws_bus.inst;
        retire.rd    = es_to_ws_bus.rd;
        retire.rf_we = es_to_ws_bus.rf_we;
        retire.data  = es_to_ws_bus.result;
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (es_to_ws_valid && es_to_ws_bus.inst == `NPC_EBREAK) begin
            halted <= 1'b1;
        end
    end

endmodule

// File: rtl/npc_top.sv
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_top import npc_pipe_pkg::*; (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               imem_we,
    input  logic [$clog2(`NPC_IMEM_DEPTH)-1:0] imem_addr,
    input  logic [31:0]                        imem_data,
    output logic                               retire_valid,
    output retire_t                            retire,
    output logic                               halted
);

    // --------------------
    // handshake
    // --------------------
    logic ds_allowin;
    logic es_allowin;
    logic ws_allowin;
    logic fs_to_ds_valid;
    logic ds_to_es_valid;
    logic es_to_ws_valid;

    // stage buses
    fs_to_ds_t fs_to_ds_bus;
    ds_to_es_t ds_to_es_bus;
    es_to_ws_t es_to_ws_bus;
    ws_to_rf_t ws_to_rf_bus;

    // register file read ports
    reg_idx_t ds_rs1;
    reg_idx_t ds_rs2;
    xlen_t    rf_rdata1;
    xlen_t    rf_rdata2;

    npc_fetch u_fetch (
        .clk            (clk),
        .reset          (reset),
        .imem_we        (imem_we),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .ds_allowin     (ds_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus)
    );

    npc_regfile u_regfile (
        .clk          (clk),
        .reset        (reset),
        .rs1          (ds_rs1),
        .rs2          (ds_rs2),
        .rdata1       (rf_rdata1),
        .rdata2       (rf_rdata2),
        .ws_to_rf_bus (ws_to_rf_bus)
    );

    npc_decode u_decode (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .ds_allowin     (ds_allowin),
        .rs1            (ds_rs1),
        .rs2            (ds_rs2),
        .rdata1         (rf_rdata1),
        .rdata2         (rf_rdata2),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus)
    );

    npc_execute u_execute (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .ws_allowin     (ws_allowin),
        .es_allowin     (es_allowin),
        .ws_to_rf_bus   (ws_to_rf_bus),
        .es_to_ws_valid (es_to_ws_valid),
        .es_to_ws_bus   (es_to_ws_bus)
    );

    npc_writeback u_writeback (
        .clk            (clk),
        .reset          (reset),
        .es_to_ws_valid (es_to_ws_valid),
        .es_to_ws_bus   (es_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .ws_to_rf_bus   (ws_to_rf_bus),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .halted         (halted)
    );

endmodule

// File: verif/npc_tb.sv
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_tb import npc_pipe_pkg::*; ();

    // opcode and function fields as the ISA manual encodes them
    localparam logic [6:0] OPC_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_REG  = 7'b0110011;
    localparam logic [6:0] OPC_LUI  = 7'b0110111;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [2:0] FN_ADD   = 3'b000;
    localparam logic [2:0] FN_SLTI  = 3'b010;
    localparam logic [2:0] FN_XOR   = 3'b100;
    localparam logic [2:0] FN_OR    = 3'b110;
    localparam logic [2:0] FN_AND   = 3'b111;
    localparam logic [6:0] FN7_BASE = 7'b0000000;
    localparam logic [6:0] FN7_SUB  = 7'b0100000;
    localparam logic [6:0] FN7_MUL  = 7'b0000001;

    localparam int HALT_WAIT  = 200;
    localparam int AFTER_HALT = 20;

    logic        clk;
    logic        reset;
    logic        imem_we;
    logic [7:0]  imem_addr;
    logic [31:0] imem_data;
    logic        retire_valid;
    retire_t     retire;
    logic        halted;

    int          seed;
    int          retired;
    logic [31:0] prog [$];
    retire_t     expected [$];
    xlen_t       model_regs [32];

    npc_top UUT (
        .clk          (clk),
        .reset        (reset),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // --------------------
    // failure and checks
    // --------------------
    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping on first error");
    endtask

    function automatic string fmt_retire(input retire_t r);
        return $sformatf("{pc=%h inst=%h rd=%0d rf_we=%b data=%h}",
                         r.pc, r.inst, r.rd, r.rf_we, r.data);
    endfunction

    task automatic check_retire(input retire_t exp, input retire_t act);
        retire_t seen;
        seen = act;
        // data carries no meaning without a register write
        if (!exp.rf_we) begin
            seen.data = exp.data;
        end
        if (seen !== exp) begin
            stop_failed($sformatf("FAILED time=%0t signal=retire expected %s actual %s",
                                  $time, fmt_retire(exp), fmt_retire(act)));
        end
    endtask

    task automatic check_halt(input logic exp, input logic act);
        if (act !== exp) begin
            stop_failed($sformatf("FAILED time=%0t signal=halted expected %b actual %b",
                                  $time, exp, act));
        end
    endtask

    // --------------------
    // reference model
    // --------------------
    function automatic retire_t step_model(input logic [31:0] inst, input xlen_t pc);
        retire_t     rec;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        xlen_t       a;
        xlen_t       b;
        xlen_t       imm_i;
        xlen_t       imm_u;
        xlen_t       value;
        logic        ok;
        opc   = inst[6:0];
        rd    = inst[11:7];
        f3    = inst[14:12];
        rs1   = inst[19:15];
        rs2   = inst[24:20];
        f7    = inst[31:25];
        a     = model_regs[rs1];
        b     = model_regs[rs2];
        imm_i = {{52{inst[31]}}, inst[31:20]};
        imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
        ok    = 1'b1;
        value = '0;
        case (opc)
            OPC_IMM: begin
                case (f3)
                    FN_ADD:  value = a + imm_i;
                    FN_XOR:  value = a ^ imm_i;
                    FN_OR:   value = a | imm_i;
                    FN_AND:  value = a & imm_i;
                    default: ok = 1'b0;
                endcase
            end
            OPC_REG: begin
                case ({f7, f3})
                    {FN7_BASE, FN_ADD}: value = a + b;
                    {FN7_SUB, FN_ADD}:  value = a - b;
                    {FN7_BASE, FN_XOR}: value = a ^ b;
                    {FN7_BASE, FN_OR}:  value = a | b;
                    {FN7_BASE, FN_AND}: value = a & b;
                    default:            ok = 1'b0;
                endcase
            end
            OPC_LUI: value = imm_u;
            default: ok = 1'b0;
        endcase
        rec.pc    = pc;
        rec.inst  = inst;
        rec.rd    = rd;
        rec.rf_we = ok && (rd != 5'd0);
        rec.data  = rec.rf_we ? value : '0;
        if (rec.rf_we) begin
            model_regs[rd] = value;
        end
        return rec;
    endfunction

    // compares every retired instruction against the next model record
    always @(posedge clk) begin : compare_retire
        retire_t want;
        if (!reset && retire_valid === 1'b1) begin
            if (expected.size() == 0) begin
                stop_failed("an instruction retired when none was expected");
            end else begin
                want = expected.pop_front();
                check_retire(want, retire);
                retired++;
            end
        end
    end

    // --------------------
    // program builders
    // --------------------
    task automatic put_itype(input logic [2:0] f3, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [11:0] imm);
        prog.push_back({imm, rs1, f3, rd, OPC_IMM});
    endtask

    task automatic put_rtype(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2);
        prog.push_back({f7, rs2, rs1, f3, rd, OPC_REG});
    endtask

    task automatic put_lui(input logic [4:0] rd, input logic [19:0] imm);
        prog.push_back({imm, rd, OPC_LUI});
    endtask

    task automatic build_alu_forms();
        prog.delete();
        put_itype(FN_ADD, 5'd1, 5'd0, 12'd100);
        // -7, must sign-extend to 64 bits
        put_itype(FN_ADD, 5'd2, 5'd0, 12'hff9);
        put_itype(FN_AND, 5'd3, 5'd2, 12'h0f0);
        put_itype(FN_OR, 5'd4, 5'd1, 12'h800);
        put_itype(FN_XOR, 5'd5, 5'd2, 12'h555);
        put_rtype(FN7_BASE, FN_ADD, 5'd6, 5'd1, 5'd2);
        put_rtype(FN7_SUB, FN_ADD, 5'd7, 5'd1, 5'd2);
        put_rtype(FN7_BASE, FN_AND, 5'd8, 5'd4, 5'd5);
        put_rtype(FN7_BASE, FN_OR, 5'd9, 5'd3, 5'd5);
        put_rtype(FN7_BASE, FN_XOR, 5'd10, 5'd6, 5'd7);
        put_lui(5'd11, 20'h80000);
        put_lui(5'd12, 20'h12345);
        put_rtype(FN7_BASE, FN_ADD, 5'd13, 5'd11, 5'd12);
        put_itype(FN_XOR, 5'd14, 5'd13, 12'hfff);
        prog.push_back(`NPC_EBREAK);
    endtask

    task automatic build_dependent();
        prog.delete();
        put_itype(FN_ADD, 5'd1, 5'd0, 12'd5);
        put_itype(FN_ADD, 5'd1, 5'd1, 12'd3);
        put_rtype(FN7_BASE, FN_ADD, 5'd2, 5'd1, 5'd1);
        // x2 one back, x1 two back
        put_rtype(FN7_SUB, FN_ADD, 5'd3, 5'd2, 5'd1);
        put_rtype(FN7_BASE, FN_XOR, 5'd4, 5'd3, 5'd2);
        put_itype(FN_ADD, 5'd0, 5'd4, 12'd77);
        put_rtype(FN7_BASE, FN_ADD, 5'd5, 5'd0, 5'd4);
        // lw, slti and mul fall outside the subset
        prog.push_back({12'h000, 5'd1, 3'b010, 5'd6, OPC_LOAD});
        put_rtype(FN7_BASE, FN_OR, 5'd7, 5'd6, 5'd0);
        put_itype(FN_SLTI, 5'd8, 5'd1, 12'd9);
        put_rtype(FN7_MUL, FN_ADD, 5'd9, 5'd1, 5'd1);
        put_rtype(FN7_BASE, FN_OR, 5'd10, 5'd9, 5'd8);
        put_rtype(FN7_BASE, FN_ADD, 5'd0, 5'd5, 5'd5);
        put_itype(FN_OR, 5'd11, 5'd0, 12'd0);
        prog.push_back(`NPC_EBREAK);
    endtask

    task automatic build_random(input int count);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          pick;
        prog.delete();
        for (int i = 0; i < count; i++) begin
            pick = $unsigned($random(seed)) % 10;
            r    = $random(seed);
            // x0..x7 only, so dependencies are dense
            rd   = {2'b00, r[2:0]};
            rs1  = {2'b00, r[5:3]};
            rs2  = {2'b00, r[8:6]};
            case (pick)
                0:       put_itype(FN_ADD, rd, rs1, r[31:20]);
                1:       put_itype(FN_AND, rd, rs1, r[31:20]);
                2:       put_itype(FN_OR, rd, rs1, r[31:20]);
                3:       put_itype(FN_XOR, rd, rs1, r[31:20]);
                4:       put_rtype(FN7_BASE, FN_ADD, rd, rs1, rs2);
                5:       put_rtype(FN7_SUB, FN_ADD, rd, rs1, rs2);
                6:       put_rtype(FN7_BASE, FN_AND, rd, rs1, rs2);
                7:       put_rtype(FN7_BASE, FN_OR, rd, rs1, rs2);
                8:       put_rtype(FN7_BASE, FN_XOR, rd, rs1, rs2);
                default: put_lui(rd, r[31:12]);
            endcase
        end
        prog.push_back(`NPC_EBREAK);
    endtask

    // --------------------
    // one program run
    // --------------------
    task automatic run_program(input string name);
        int      cycles;
        int      start_count;
        retire_t rec;
        @(negedge clk);
        reset = 1'b1;
        expected.delete();
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < prog.size(); i++) begin
            rec = step_model(prog[i], 64'(i) * 64'd4);
            expected.push_back(rec);
        end
        // program goes in while reset is held
        for (int i = 0; i < prog.size(); i++) begin
            imem_we   = 1'b1;
            imem_addr = 8'(i);
            imem_data = prog[i];
            @(negedge clk);
        end
        imem_we = 1'b0;
        repeat (8) @(negedge clk);
        start_count = retired;
        reset       = 1'b0;

        cycles = 0;
        while (halted !== 1'b1) begin
            if (cycles == HALT_WAIT) begin
                stop_failed($sformatf("program %s did not halt within %0d cycles",
                                      name, HALT_WAIT));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end

        if (expected.size() != 0) begin
            stop_failed($sformatf("program %s halted with %0d instructions not retired",
                                  name, expected.size()));
        end else begin
            // stays halted, nothing else retires
            for (int c = 0; c < AFTER_HALT; c++) begin
                @(negedge clk);
                check_halt(1'b1, halted);
            end
            $display("program %s: %0d instructions retired", name, retired - start_count);
        end
    endtask

    initial begin
        seed      = 17721;
        retired   = 0;
        reset     = 1'b1;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;

        build_alu_forms();
        run_program("alu_forms");
        build_dependent();
        run_program("dependent");
        build_random(150);
        run_program("random");

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: src.f
+incdir+rtl
rtl/npc_isa_pkg.sv
rtl/npc_pipe_pkg.sv
rtl/npc_fetch.sv
rtl/npc_regfile.sv
rtl/npc_decode.sv
rtl/npc_execute.sv
rtl/npc_writeback.sv
rtl/npc_top.sv
verif/npc_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module npc_tb -o npc_sim

# exit status is nonzero when the testbench stops on an error
./obj_dir/npc_sim
